// ==== src.f ====
hw/rtos_pkg.sv
hw/rtos_axil_slave.sv
hw/rtos_reg_map.sv
hw/rtos_ready_table.sv
hw/rtos_sem_bank.sv
hw/rtos_event_flag.sv
hw/rtos_cpu_ctl.sv
hw/rtos_top.sv
verif/tb_clkgen.sv
verif/tb_checker.sv
verif/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# compile with Verilator and run the testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_top -f src.f -o tb_top_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_top_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "no result line in sim.log"
    exit 1
fi
exit 0

// ==== verif/tb_top.sv ====
module tb_top;

    typedef struct packed {
        logic                             wr;
        logic [rtos_pkg::AXIL_ADDR_W-1:0] addr;
        logic [rtos_pkg::AXIL_DATA_W-1:0] wdata;
        logic [rtos_pkg::AXIL_DATA_W-1:0] exp_rdata;
        logic [rtos_pkg::FLG_W-1:0]       exp_flg;
        logic                             exp_irq;
        logic [rtos_pkg::IDLE_ID_W-1:0]   exp_top;
    } step_t;

    localparam int WAIT_LIMIT = 64;

    logic                               clk;
    logic                               reset;
    logic [rtos_pkg::AXIL_ADDR_W-1:0]   awaddr;
    logic                               awvalid;
    logic                               awready;
    logic [rtos_pkg::AXIL_DATA_W-1:0]   wdata;
    logic [3:0]                         wstrb;
    logic                               wvalid;
    logic                               wready;
    logic [1:0]                         bresp;
    logic                               bvalid;
    logic                               bready;
    logic [rtos_pkg::AXIL_ADDR_W-1:0]   araddr;
    logic                               arvalid;
    logic                               arready;
    logic [rtos_pkg::AXIL_DATA_W-1:0]   rdata;
    logic [1:0]                         rresp;
    logic                               rvalid;
    logic                               rready;
    logic [rtos_pkg::FLG_W-1:0]         ext_flg;
    logic                               irq;
    logic [rtos_pkg::FLG_W-1:0]         mon_flgptn;
    logic [rtos_pkg::TSKID_W-1:0]       mon_top_tskid;
    logic [rtos_pkg::IDLE_ID_W-1:0]     top_now;
    step_t                              steps[$];
    step_t                              cur_step;
    int                                 mismatches;
    int                                 timeouts;
    bit                                 aborted;

    tb_clkgen u_clkgen (.clk_o (clk));

    rtos_top DUT (
        .clk              (clk),
        .reset_i          (reset),
        .s_axil_awaddr_i  (awaddr),
        .s_axil_awvalid_i (awvalid),
        .s_axil_awready_o (awready),
        .s_axil_wdata_i   (wdata),
        .s_axil_wstrb_i   (wstrb),
        .s_axil_wvalid_i  (wvalid),
        .s_axil_wready_o  (wready),
        .s_axil_bresp_o   (bresp),
        .s_axil_bvalid_o  (bvalid),
        .s_axil_bready_i  (bready),
        .s_axil_araddr_i  (araddr),
        .s_axil_arvalid_i (arvalid),
        .s_axil_arready_o (arready),
        .s_axil_rdata_o   (rdata),
        .s_axil_rresp_o   (rresp),
        .s_axil_rvalid_o  (rvalid),
        .s_axil_rready_i  (rready),
        .ext_flg_i        (ext_flg),
        .irq_o            (irq),
        .mon_flgptn_o     (mon_flgptn),
        .mon_top_tskid_o  (mon_top_tskid)
    );

    tb_checker u_checker (
        .clk          (clk),
        .reset_i      (reset),
        .bvalid_i     (bvalid),
        .bready_i     (bready),
        .bresp_i      (bresp),
        .rvalid_i     (rvalid),
        .rready_i     (rready),
        .rresp_i      (rresp),
        .rdata_i      (rdata),
        .flgptn_i     (mon_flgptn),
        .irq_i        (irq),
        .top_tskid_i  (mon_top_tskid),
        .exp_wr_i     (cur_step.wr),
        .exp_rdata_i  (cur_step.exp_rdata),
        .exp_flgptn_i (cur_step.exp_flg),
        .exp_irq_i    (cur_step.exp_irq),
        .exp_top_i    (cur_step.exp_top),
        .errors_o     (mismatches)
    );

    // byte address is opcode * 1024 + id * 4
    function automatic logic [rtos_pkg::AXIL_ADDR_W-1:0] addr_of(
        input logic [7:0] opc,
        input logic [7:0] id
    );
        return {opc, id, 2'b00};
    endfunction

    task automatic add_write(input logic [7:0] opc, input logic [7:0] id,
                             input logic [31:0] data, input logic [31:0] flg,
                             input logic irq_exp);
        step_t s;
        s = '0;
        s.wr      = 1'b1;
        s.addr    = addr_of(opc, id);
        s.wdata   = data;
        s.exp_flg = flg;
        s.exp_irq = irq_exp;
        s.exp_top = top_now;
        steps.push_back(s);
    endtask

    task automatic add_read(input logic [7:0] opc, input logic [7:0] id,
                            input logic [31:0] exp_data, input logic [31:0] flg,
                            input logic irq_exp);
        step_t s;
        s = '0;
        s.addr      = addr_of(opc, id);
        s.exp_rdata = exp_data;
        s.exp_flg   = flg;
        s.exp_irq   = irq_exp;
        s.exp_top   = top_now;
        steps.push_back(s);
    endtask

    // ----------------------------------------
    // stimulus table
    // ----------------------------------------
    task automatic build_table();
        logic [31:0] merged;
        merged = 32'h30 | (ext_flg & 32'h0000_0f00);
        // top task after each step takes effect, 8 while none is ready
        top_now = 4'd8;
        add_read(rtos_pkg::OPC_SYS_CFG, rtos_pkg::CFG_CORE_ID, 32'h834f5452, 32'h0, 1'b0);
        add_read(rtos_pkg::OPC_SYS_CFG, rtos_pkg::CFG_TASKS, 32'd8, 32'h0, 1'b0);
        add_read(rtos_pkg::OPC_SYS_CFG, rtos_pkg::CFG_SEMAPHORES, 32'd4, 32'h0, 1'b0);
        add_read(rtos_pkg::OPC_SYS_CFG, rtos_pkg::CFG_FLGPTN_W, 32'd32, 32'h0, 1'b0);
        // ready table reads idle id 8 while empty
        add_read(rtos_pkg::OPC_CPU_CTL, rtos_pkg::CTL_TOP_TSKID, 32'd8, 32'h0, 1'b0);
        add_read(rtos_pkg::OPC_CPU_CTL, rtos_pkg::CTL_TOP_VALID, 32'd0, 32'h0, 1'b0);
        top_now = 4'd5;
        add_write(rtos_pkg::OPC_WUP_TSK, 8'd5, 32'h0, 32'h0, 1'b0);
        top_now = 4'd2;
        add_write(rtos_pkg::OPC_WUP_TSK, 8'd2, 32'h0, 32'h0, 1'b0);
        add_read(rtos_pkg::OPC_CPU_CTL, rtos_pkg::CTL_TOP_TSKID, 32'd2, 32'h0, 1'b0);
        add_read(rtos_pkg::OPC_CPU_CTL, rtos_pkg::CTL_TOP_VALID, 32'd1, 32'h0, 1'b0);
        top_now = 4'd5;
        add_write(rtos_pkg::OPC_SLP_TSK, 8'd2, 32'h0, 32'h0, 1'b0);
        add_read(rtos_pkg::OPC_CPU_CTL, rtos_pkg::CTL_TOP_TSKID, 32'd5, 32'h0, 1'b0);
        // semaphore 1 with counts in nibbles
        add_write(rtos_pkg::OPC_SIG_SEM, 8'd1, 32'h0, 32'h0, 1'b0);
        add_write(rtos_pkg::OPC_SIG_SEM, 8'd1, 32'h0, 32'h0, 1'b0);
        add_read(rtos_pkg::OPC_REF_SEMCNT, 8'd0, 32'h20, 32'h0, 1'b0);
        add_read(rtos_pkg::OPC_POL_SEM, 8'd1, 32'd1, 32'h0, 1'b0);
        add_read(rtos_pkg::OPC_POL_SEM, 8'd1, 32'd1, 32'h0, 1'b0);
        add_read(rtos_pkg::OPC_POL_SEM, 8'd1, 32'd0, 32'h0, 1'b0);
        add_read(rtos_pkg::OPC_REF_SEMCNT, 8'd0, 32'h0, 32'h0, 1'b0);
        // event flags
        add_write(rtos_pkg::OPC_SET_FLG, 8'd0, 32'h0000_00f0, 32'h0000_00f0, 1'b0);
        add_write(rtos_pkg::OPC_CLR_FLG, 8'd0, 32'hffff_ff3f, 32'h30, 1'b0);
        // enable lands at the handshake edge, external bits merge one cycle later
        add_write(rtos_pkg::OPC_ENA_FLG_EXT, 8'd0, 32'h0000_0f00, 32'h30, 1'b0);
        add_read(rtos_pkg::OPC_SET_FLG, 8'd0, 32'h0, merged, 1'b0);
        // cpu control and task switch irq
        add_write(rtos_pkg::OPC_CPU_CTL, rtos_pkg::CTL_RUN_TSKID, 32'd3, merged, 1'b0);
        add_write(rtos_pkg::OPC_CPU_CTL, rtos_pkg::CTL_IRQ_EN, 32'd1, merged, 1'b1);
        add_read(rtos_pkg::OPC_CPU_CTL, rtos_pkg::CTL_IRQ_STS, 32'd1, merged, 1'b1);
        // irq still up in the response cycle and gone two cycles after the match
        add_read(rtos_pkg::OPC_CPU_CTL, rtos_pkg::CTL_COPY_TSKID, 32'd5, merged, 1'b1);
        add_read(rtos_pkg::OPC_CPU_CTL, rtos_pkg::CTL_IRQ_STS, 32'd0, merged, 1'b0);
        add_read(rtos_pkg::OPC_CPU_CTL, rtos_pkg::CTL_RUN_TSKID, 32'd5, merged, 1'b0);
        add_write(rtos_pkg::OPC_CPU_CTL, rtos_pkg::CTL_IRQ_FORCE, 32'd1, merged, 1'b1);
        add_read(rtos_pkg::OPC_CPU_CTL, rtos_pkg::CTL_IRQ_STS, 32'd1, merged, 1'b1);
    endtask

    // ----------------------------------------
    // bus driver
    // ----------------------------------------
    task automatic run_step(input step_t s, output bit ok);
        int    n;
        string kind;
        ok = 1'b1;
        if (s.wr) begin
            kind = "write";
        end else begin
            kind = "read";
        end
        cur_step <= s;
        if (s.wr) begin
            awaddr  <= s.addr;
            wdata   <= s.wdata;
            wstrb   <= 4'hf;
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
        end else begin
            araddr  <= s.addr;
            arvalid <= 1'b1;
        end
        n = 0;
        while (!(s.wr ? (awready && wready) : arready) && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        arvalid <= 1'b0;
        if (!(s.wr ? (awready && wready) : arready)) begin
            ok = 1'b0;
            $display("timeout: the DUT did not accept the %s within %0d cycles", kind, n);
        end else begin
            n = 0;
            while (!(s.wr ? bvalid : rvalid) && n < WAIT_LIMIT) begin
                @(posedge clk);
                n++;
            end
            if (!(s.wr ? bvalid : rvalid)) begin
                ok = 1'b0;
                $display("timeout: no %s response from the DUT within %0d cycles", kind, n);
            end else begin
                repeat (4) @(posedge clk);
            end
        end
    endtask

    initial begin
        bit ok;
        reset    = 1'b1;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        wvalid   = 1'b0;
        bready   = 1'b1;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b1;
        cur_step = '0;
        top_now  = '0;
        timeouts = 0;
        aborted  = 1'b0;
        void'($urandom(72));
        ext_flg = $urandom();
        build_table();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        foreach (steps[i]) begin
            if (!aborted) begin
                run_step(steps[i], ok);
                if (!ok) begin
                    timeouts++;
                    aborted = 1'b1;
                end
            end
        end
        $display("errors: %0d value mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== verif/tb_checker.sv ====
module tb_checker (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              bvalid_i,
    input  logic                              bready_i,
    input  logic [1:0]                        bresp_i,
    input  logic                              rvalid_i,
    input  logic                              rready_i,
    input  logic [1:0]                        rresp_i,
    input  logic [31:0]                       rdata_i,
    input  logic [31:0]                       flgptn_i,
    input  logic                              irq_i,
    input  logic [rtos_pkg::TSKID_W-1:0]      top_tskid_i,
    input  logic                              exp_wr_i,
    input  logic [31:0]                       exp_rdata_i,
    input  logic [31:0]                       exp_flgptn_i,
    input  logic                              exp_irq_i,
    input  logic [rtos_pkg::IDLE_ID_W-1:0]    exp_top_i,
    output int                                errors_o
);

    int errors = 0;

    task automatic report_mismatch(input string msg);
        errors++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    // state as seen in the cycle of the response
    task automatic compare_state();
        if (flgptn_i !== exp_flgptn_i) begin
            report_mismatch($sformatf("flag pattern %08h, expected %08h",
                                      flgptn_i, exp_flgptn_i));
        end
        if (irq_i !== exp_irq_i) begin
            report_mismatch($sformatf("irq_o %0b, expected %0b", irq_i, exp_irq_i));
        end
        // the top task monitor has no defined value while no task is ready
        if (exp_top_i < rtos_pkg::TASKS
            && top_tskid_i !== exp_top_i[rtos_pkg::TSKID_W-1:0]) begin
            report_mismatch($sformatf("top task %0d, expected %0d",
                                      top_tskid_i, exp_top_i));
        end
    endtask

    always @(posedge clk) begin
        if (!reset_i && bvalid_i && bready_i) begin
            if (!exp_wr_i) begin
                report_mismatch("write response during a read step");
            end
            if (bresp_i !== 2'b00) begin
                report_mismatch($sformatf("bresp %0d, expected OKAY", bresp_i));
            end
            compare_state();
        end
        if (!reset_i && rvalid_i && rready_i) begin
            if (exp_wr_i) begin
                report_mismatch("read response during a write step");
            end
            if (rresp_i !== 2'b00) begin
                report_mismatch($sformatf("rresp %0d, expected OKAY", rresp_i));
            end
            if (rdata_i !== exp_rdata_i) begin
                report_mismatch($sformatf("read data %08h, expected %08h",
                                          rdata_i, exp_rdata_i));
            end
            compare_state();
        end
    end

    assign errors_o = errors;

endmodule

// ==== verif/tb_clkgen.sv ====
module tb_clkgen #(
    parameter int PERIOD = 10
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

// ==== hw/rtos_top.sv ====
module rtos_top (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic [rtos_pkg::AXIL_ADDR_W-1:0]    s_axil_awaddr_i,
    input  logic                                s_axil_awvalid_i,
    output logic                                s_axil_awready_o,
    input  logic [rtos_pkg::AXIL_DATA_W-1:0]    s_axil_wdata_i,
    input  logic [rtos_pkg::AXIL_DATA_W/8-1:0]  s_axil_wstrb_i,
    input  logic                                s_axil_wvalid_i,
    output logic                                s_axil_wready_o,
    output logic [1:0]                          s_axil_bresp_o,
    output logic                                s_axil_bvalid_o,
    input  logic                                s_axil_bready_i,
    input  logic [rtos_pkg::AXIL_ADDR_W-1:0]    s_axil_araddr_i,
    input  logic                                s_axil_arvalid_i,
    output logic                                s_axil_arready_o,
    output logic [rtos_pkg::AXIL_DATA_W-1:0]    s_axil_rdata_o,
    output logic [1:0]                          s_axil_rresp_o,
    output logic                                s_axil_rvalid_o,
    input  logic                                s_axil_rready_i,
    input  logic [rtos_pkg::FLG_W-1:0]          ext_flg_i,
    output logic                                irq_o,
    output logic [rtos_pkg::FLG_W-1:0]          mon_flgptn_o,
    output logic [rtos_pkg::TSKID_W-1:0]        mon_top_tskid_o
);

    rtos_pkg::reg_req_t                     req;
    rtos_pkg::task_cmd_t                    task_cmd;
    rtos_pkg::sem_cmd_t                     sem_cmd;
    rtos_pkg::flg_cmd_t                     flg_cmd;
    rtos_pkg::unit_req_t                    ctl_req;
    logic [rtos_pkg::AXIL_DATA_W-1:0]       rdata;
    logic [rtos_pkg::AXIL_DATA_W-1:0]       ctl_rdata;
    logic                                   pol_ack;
    logic [rtos_pkg::SEMAPHORES-1:0][rtos_pkg::SEMCNT_W-1:0] semcnt;
    logic                                   top_valid;

    // ----------------------------------------
    // bus side
    // ----------------------------------------
    rtos_axil_slave u_axil_slave (
        .clk, .reset_i,
        .s_axil_awaddr_i, .s_axil_awvalid_i, .s_axil_awready_o,
        .s_axil_wdata_i, .s_axil_wstrb_i, .s_axil_wvalid_i, .s_axil_wready_o,
        .s_axil_bresp_o, .s_axil_bvalid_o, .s_axil_bready_i,
        .s_axil_araddr_i, .s_axil_arvalid_i, .s_axil_arready_o,
        .s_axil_rdata_o, .s_axil_rresp_o, .s_axil_rvalid_o, .s_axil_rready_i,
        .req_o   (req),
        .rdata_i (rdata)
    );

    rtos_reg_map u_reg_map (
        .req_i       (req),
        .task_o      (task_cmd),
        .sem_o       (sem_cmd),
        .flg_o       (flg_cmd),
        .ctl_o       (ctl_req),
        .pol_ack_i   (pol_ack),
        .semcnt_i    (semcnt),
        .ctl_rdata_i (ctl_rdata),
        .rdata_o     (rdata)
    );

    // ----------------------------------------
    // scheduler units
    // ----------------------------------------
    rtos_ready_table u_ready_table (
        .clk, .reset_i,
        .cmd_i       (task_cmd),
        .top_tskid_o (mon_top_tskid_o),
        .top_valid_o (top_valid)
    );

    rtos_sem_bank u_sem_bank (
        .clk, .reset_i,
        .cmd_i     (sem_cmd),
        .pol_ack_o (pol_ack),
        .semcnt_o  (semcnt)
    );

    rtos_event_flag u_event_flag (
        .clk, .reset_i,
        .cmd_i     (flg_cmd),
        .ext_flg_i,
        .flgptn_o  (mon_flgptn_o)
    );

    rtos_cpu_ctl u_cpu_ctl (
        .clk, .reset_i,
        .req_i       (ctl_req),
        .top_tskid_i (mon_top_tskid_o),
        .top_valid_i (top_valid),
        .rdata_o     (ctl_rdata),
        .irq_o
    );

endmodule

// ==== hw/rtos_cpu_ctl.sv ====
module rtos_cpu_ctl (
    input  logic                                clk,
    input  logic                                reset_i,
    input  rtos_pkg::unit_req_t                 req_i,
    input  logic [rtos_pkg::TSKID_W-1:0]        top_tskid_i,
    input  logic                                top_valid_i,
    output logic [rtos_pkg::AXIL_DATA_W-1:0]    rdata_o,
    output logic                                irq_o
);

    logic [rtos_pkg::TSKID_W-1:0]   run_tskid;
    logic                           run_valid;
    logic [rtos_pkg::IDLE_ID_W-1:0] idle_tskid;
    logic [rtos_pkg::IDLE_ID_W-1:0] cur_top;
    logic [rtos_pkg::IDLE_ID_W-1:0] cur_run;
    logic                           irq_en;
    logic                           irq_force;
    logic                           reg_switch;
    logic                           reg_irq;
    logic                           differ;

    // idle id stands in when nothing is ready or running
    assign cur_top = top_valid_i ? rtos_pkg::IDLE_ID_W'(top_tskid_i) : idle_tskid;
    assign cur_run = run_valid ? rtos_pkg::IDLE_ID_W'(run_tskid) : idle_tskid;
    assign differ  = (cur_top != cur_run);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            run_tskid  <= '0;
            run_valid  <= 1'b0;
            idle_tskid <= rtos_pkg::IDLE_ID_W'(rtos_pkg::TASKS);
            irq_en     <= 1'b0;
            irq_force  <= 1'b0;
            reg_switch <= 1'b0;
            reg_irq    <= 1'b0;
        end else begin
            if (req_i.wr) begin
                case (req_i.id)
                    rtos_pkg::CTL_RUN_TSKID: begin
                        run_tskid <= req_i.wdata[rtos_pkg::TSKID_W-1:0];
                        run_valid <= (req_i.wdata < rtos_pkg::AXIL_DATA_W'(rtos_pkg::TASKS));
                    end
                    rtos_pkg::CTL_RUN_VALID:  run_valid  <= req_i.wdata[0];
                    rtos_pkg::CTL_IDLE_TSKID: idle_tskid <= req_i.wdata[rtos_pkg::IDLE_ID_W-1:0];
                    rtos_pkg::CTL_IRQ_EN:     irq_en     <= req_i.wdata[0];
                    rtos_pkg::CTL_IRQ_FORCE:  irq_force  <= req_i.wdata[0];
                    default: ;
                endcase
            end
            // reading copy_tskid hands the top task to the cpu
            if (req_i.rd && (req_i.id == rtos_pkg::CTL_COPY_TSKID)) begin
                run_tskid <= top_tskid_i;
                run_valid <= top_valid_i;
            end
            // switch needs two consecutive cycles of mismatch
            reg_switch <= differ;
            reg_irq    <= differ && reg_switch;
        end
    end

    assign irq_o = (reg_irq && irq_en) || irq_force;

    always_comb begin
        case (req_i.id)
            rtos_pkg::CTL_TOP_TSKID:  rdata_o = rtos_pkg::AXIL_DATA_W'(cur_top);
            rtos_pkg::CTL_TOP_VALID:  rdata_o = rtos_pkg::AXIL_DATA_W'(top_valid_i);
            rtos_pkg::CTL_RUN_TSKID:  rdata_o = rtos_pkg::AXIL_DATA_W'(cur_run);
            rtos_pkg::CTL_RUN_VALID:  rdata_o = rtos_pkg::AXIL_DATA_W'(run_valid);
            rtos_pkg::CTL_IDLE_TSKID: rdata_o = rtos_pkg::AXIL_DATA_W'(idle_tskid);
            rtos_pkg::CTL_COPY_TSKID: rdata_o = rtos_pkg::AXIL_DATA_W'(cur_top);
            rtos_pkg::CTL_IRQ_EN:     rdata_o = rtos_pkg::AXIL_DATA_W'(irq_en);
            rtos_pkg::CTL_IRQ_STS:    rdata_o = rtos_pkg::AXIL_DATA_W'(irq_o);
            rtos_pkg::CTL_IRQ_FORCE:  rdata_o = rtos_pkg::AXIL_DATA_W'(irq_force);
            default:                  rdata_o = '0;
        endcase
    end

endmodule

// ==== hw/rtos_event_flag.sv ====
module rtos_event_flag (
    input  logic                        clk,
    input  logic                        reset_i,
    input  rtos_pkg::flg_cmd_t          cmd_i,
    input  logic [rtos_pkg::FLG_W-1:0]  ext_flg_i,
    output logic [rtos_pkg::FLG_W-1:0]  flgptn_o
);

    logic [rtos_pkg::FLG_W-1:0] ext_en;
    logic [rtos_pkg::FLG_W-1:0] flg_next;

    always_comb begin
        flg_next = flgptn_o;
        if (cmd_i.set) begin
            flg_next = flg_next | cmd_i.data;
        end
        if (cmd_i.clr) begin
            flg_next = flg_next & cmd_i.data;
        end
        // enabled external flags merge every cycle
        flg_next = flg_next | (ext_flg_i & ext_en);
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            flgptn_o <= '0;
            ext_en   <= '0;
        end else begin
            flgptn_o <= flg_next;
            if (cmd_i.ena_wr) begin
                ext_en <= cmd_i.data;
            end
        end
    end

endmodule

// ==== hw/rtos_sem_bank.sv ====
module rtos_sem_bank (
    input  logic                    clk,
    input  logic                    reset_i,
    input  rtos_pkg::sem_cmd_t      cmd_i,
    output logic                    pol_ack_o,
    output logic [rtos_pkg::SEMAPHORES-1:0][rtos_pkg::SEMCNT_W-1:0] semcnt_o
);

    logic [rtos_pkg::SEMCNT_W-1:0] cur_cnt;

    assign cur_cnt   = semcnt_o[cmd_i.semid];
    // a poll succeeds only on a nonzero count
    assign pol_ack_o = (cur_cnt != '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            semcnt_o <= '0;
        end else begin
            if (cmd_i.sig && (cur_cnt != '1)) begin
                // saturate at full count
                semcnt_o[cmd_i.semid] <= cur_cnt + 1'b1;
            end else if (cmd_i.pol && pol_ack_o) begin
                semcnt_o[cmd_i.semid] <= cur_cnt - 1'b1;
            end
        end
    end

endmodule

// ==== hw/rtos_ready_table.sv ====
module rtos_ready_table (
    input  logic                            clk,
    input  logic                            reset_i,
    input  rtos_pkg::task_cmd_t             cmd_i,
    output logic [rtos_pkg::TSKID_W-1:0]    top_tskid_o,
    output logic                            top_valid_o
);

    logic [rtos_pkg::TASKS-1:0] ready;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ready <= '0;
        end else if (cmd_i.wup) begin
            ready[cmd_i.tskid] <= 1'b1;
        end else if (cmd_i.slp) begin
            ready[cmd_i.tskid] <= 1'b0;
        end
    end

    // scanning from the top down leaves the lowest ready id
    always_comb begin
        top_tskid_o = '0;
        for (int i = rtos_pkg::TASKS - 1; i >= 0; i--) begin
            if (ready[i]) begin
                top_tskid_o = rtos_pkg::TSKID_W'(i);
            end
        end
    end

    assign top_valid_o = |ready;

endmodule

// ==== hw/rtos_reg_map.sv ====
module rtos_reg_map (
    input  rtos_pkg::reg_req_t                  req_i,
    output rtos_pkg::task_cmd_t                 task_o,
    output rtos_pkg::sem_cmd_t                  sem_o,
    output rtos_pkg::flg_cmd_t                  flg_o,
    output rtos_pkg::unit_req_t                 ctl_o,
    input  logic                                pol_ack_i,
    input  logic [rtos_pkg::SEMAPHORES-1:0][rtos_pkg::SEMCNT_W-1:0] semcnt_i,
    input  logic [rtos_pkg::AXIL_DATA_W-1:0]    ctl_rdata_i,
    output logic [rtos_pkg::AXIL_DATA_W-1:0]    rdata_o
);

    // ----------------------------------------
    // command routing
    // ----------------------------------------
    always_comb begin
        task_o.wup   = req_i.wr && (req_i.opc == rtos_pkg::OPC_WUP_TSK);
        task_o.slp   = req_i.wr && (req_i.opc == rtos_pkg::OPC_SLP_TSK);
        task_o.tskid = req_i.id[rtos_pkg::TSKID_W-1:0];

        sem_o.sig   = req_i.wr && (req_i.opc == rtos_pkg::OPC_SIG_SEM);
        sem_o.pol   = req_i.rd && (req_i.opc == rtos_pkg::OPC_POL_SEM);
        sem_o.semid = req_i.id[rtos_pkg::SEMID_W-1:0];

        flg_o.set    = req_i.wr && (req_i.opc == rtos_pkg::OPC_SET_FLG);
        flg_o.clr    = req_i.wr && (req_i.opc == rtos_pkg::OPC_CLR_FLG);
        flg_o.ena_wr = req_i.wr && (req_i.opc == rtos_pkg::OPC_ENA_FLG_EXT);
        flg_o.data   = req_i.wdata;

        // cpu control decodes its own id
        ctl_o.wr    = req_i.wr && (req_i.opc == rtos_pkg::OPC_CPU_CTL);
        ctl_o.rd    = req_i.rd && (req_i.opc == rtos_pkg::OPC_CPU_CTL);
        ctl_o.id    = req_i.id;
        ctl_o.wdata = req_i.wdata;
    end

    // ----------------------------------------
    // read data
    // ----------------------------------------
    always_comb begin
        rdata_o = '0;
        case (req_i.opc)
            rtos_pkg::OPC_SYS_CFG: begin
                case (req_i.id)
                    rtos_pkg::CFG_CORE_ID:    rdata_o = rtos_pkg::CORE_ID_VALUE;
                    rtos_pkg::CFG_TASKS:      rdata_o = rtos_pkg::AXIL_DATA_W'(rtos_pkg::TASKS);
                    rtos_pkg::CFG_SEMAPHORES: rdata_o = rtos_pkg::AXIL_DATA_W'(rtos_pkg::SEMAPHORES);
                    rtos_pkg::CFG_FLGPTN_W:   rdata_o = rtos_pkg::AXIL_DATA_W'(rtos_pkg::FLG_W);
                    default:                  rdata_o = '0;
                endcase
            end
            rtos_pkg::OPC_CPU_CTL:    rdata_o = ctl_rdata_i;
            rtos_pkg::OPC_POL_SEM:    rdata_o = rtos_pkg::AXIL_DATA_W'(pol_ack_i);
            // semaphore 0 in the low nibble
            rtos_pkg::OPC_REF_SEMCNT: rdata_o = rtos_pkg::AXIL_DATA_W'(semcnt_i);
            default:                  rdata_o = '0;
        endcase
    end

endmodule

// ==== hw/rtos_axil_slave.sv ====
module rtos_axil_slave (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic [rtos_pkg::AXIL_ADDR_W-1:0]    s_axil_awaddr_i,
    input  logic                                s_axil_awvalid_i,
    output logic                                s_axil_awready_o,
    input  logic [rtos_pkg::AXIL_DATA_W-1:0]    s_axil_wdata_i,
    input  logic [rtos_pkg::AXIL_DATA_W/8-1:0]  s_axil_wstrb_i,
    input  logic                                s_axil_wvalid_i,
    output logic                                s_axil_wready_o,
    output logic [1:0]                          s_axil_bresp_o,
    output logic                                s_axil_bvalid_o,
    input  logic                                s_axil_bready_i,
    input  logic [rtos_pkg::AXIL_ADDR_W-1:0]    s_axil_araddr_i,
    input  logic                                s_axil_arvalid_i,
    output logic                                s_axil_arready_o,
    output logic [rtos_pkg::AXIL_DATA_W-1:0]    s_axil_rdata_o,
    output logic [1:0]                          s_axil_rresp_o,
    output logic                                s_axil_rvalid_o,
    input  logic                                s_axil_rready_i,
    output rtos_pkg::reg_req_t                  req_o,
    input  logic [rtos_pkg::AXIL_DATA_W-1:0]    rdata_i
);

    logic wr_start;
    logic rd_start;

    // a pending response blocks the next beat; write wins a tie
    assign wr_start = s_axil_awvalid_i && s_axil_wvalid_i && !s_axil_bvalid_o
                      && !s_axil_awready_o;
    assign rd_start = s_axil_arvalid_i && !s_axil_rvalid_o && !s_axil_arready_o
                      && !wr_start;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            s_axil_awready_o <= 1'b0;
            s_axil_arready_o <= 1'b0;
            s_axil_bvalid_o  <= 1'b0;
            s_axil_rvalid_o  <= 1'b0;
        end else begin
            s_axil_awready_o <= wr_start;
            s_axil_arready_o <= rd_start;
            if (s_axil_awready_o) begin
                s_axil_bvalid_o <= 1'b1;
            end else if (s_axil_bready_i) begin
                s_axil_bvalid_o <= 1'b0;
            end
            if (s_axil_arready_o) begin
                s_axil_rvalid_o <= 1'b1;
            end else if (s_axil_rready_i) begin
                s_axil_rvalid_o <= 1'b0;
            end
        end
    end

    // read data held for the response
    always_ff @(posedge clk) begin
        if (s_axil_arready_o) begin
            s_axil_rdata_o <= rdata_i;
        end
    end

    assign s_axil_wready_o = s_axil_awready_o;
    assign s_axil_bresp_o  = 2'b00;
    assign s_axil_rresp_o  = 2'b00;

    // one request strobe per accepted beat
    always_comb begin
        req_o = '0;
        if (s_axil_awready_o) begin
            // partial strobes still complete, but do nothing
            req_o.wr    = &s_axil_wstrb_i;
            req_o.opc   = s_axil_awaddr_i[rtos_pkg::OPC_POS +: rtos_pkg::OPC_W];
            req_o.id    = s_axil_awaddr_i[rtos_pkg::ID_POS +: rtos_pkg::ID_W];
            req_o.wdata = s_axil_wdata_i;
        end else if (s_axil_arready_o) begin
            req_o.rd  = 1'b1;
            req_o.opc = s_axil_araddr_i[rtos_pkg::OPC_POS +: rtos_pkg::OPC_W];
            req_o.id  = s_axil_araddr_i[rtos_pkg::ID_POS +: rtos_pkg::ID_W];
        end
    end

endmodule

// ==== hw/rtos_pkg.sv ====
package rtos_pkg;

    // ----------------------------------------
    // sizes
    // ----------------------------------------
    localparam int TASKS       = 8;
    localparam int IDLE_ID_W   = 4;
    localparam int TSKID_W     = 3;
    localparam int SEMAPHORES  = 4;
    localparam int SEMID_W     = 2;
    localparam int SEMCNT_W    = 4;
    localparam int FLG_W       = 32;
    localparam int AXIL_ADDR_W = 18;
    localparam int AXIL_DATA_W = 32;

    // byte address = opcode * 1024 + id * 4
    localparam int ID_POS  = 2;
    localparam int ID_W    = 8;
    localparam int OPC_POS = 10;
    localparam int OPC_W   = 8;

    // ----------------------------------------
    // opcodes and register ids
    // ----------------------------------------
    localparam logic [OPC_W-1:0] OPC_SYS_CFG     = 8'h00;
    localparam logic [OPC_W-1:0] OPC_CPU_CTL     = 8'h01;
    localparam logic [OPC_W-1:0] OPC_WUP_TSK     = 8'h10;
    localparam logic [OPC_W-1:0] OPC_SLP_TSK     = 8'h11;
    localparam logic [OPC_W-1:0] OPC_SIG_SEM     = 8'h21;
    localparam logic [OPC_W-1:0] OPC_POL_SEM     = 8'h23;
    localparam logic [OPC_W-1:0] OPC_REF_SEMCNT  = 8'h28;
    localparam logic [OPC_W-1:0] OPC_SET_FLG     = 8'h31;
    localparam logic [OPC_W-1:0] OPC_CLR_FLG     = 8'h32;
    localparam logic [OPC_W-1:0] OPC_ENA_FLG_EXT = 8'h3a;

    localparam logic [ID_W-1:0] CFG_CORE_ID    = 8'h00;
    localparam logic [ID_W-1:0] CFG_TASKS      = 8'h20;
    localparam logic [ID_W-1:0] CFG_SEMAPHORES = 8'h21;
    localparam logic [ID_W-1:0] CFG_FLGPTN_W   = 8'h32;
    localparam logic [AXIL_DATA_W-1:0] CORE_ID_VALUE = 32'h834f5452;

    localparam logic [ID_W-1:0] CTL_TOP_TSKID  = 8'h00;
    localparam logic [ID_W-1:0] CTL_TOP_VALID  = 8'h01;
    localparam logic [ID_W-1:0] CTL_RUN_TSKID  = 8'h04;
    localparam logic [ID_W-1:0] CTL_RUN_VALID  = 8'h05;
    localparam logic [ID_W-1:0] CTL_IDLE_TSKID = 8'h07;
    localparam logic [ID_W-1:0] CTL_COPY_TSKID = 8'h08;
    localparam logic [ID_W-1:0] CTL_IRQ_EN     = 8'h10;
    localparam logic [ID_W-1:0] CTL_IRQ_STS    = 8'h11;
    localparam logic [ID_W-1:0] CTL_IRQ_FORCE  = 8'h1f;

    // ----------------------------------------
    // command structs
    // ----------------------------------------
    typedef struct packed {
        logic                   wr;
        logic                   rd;
        logic [OPC_W-1:0]       opc;
        logic [ID_W-1:0]        id;
        logic [AXIL_DATA_W-1:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic                   wr;
        logic                   rd;
        logic [ID_W-1:0]        id;
        logic [AXIL_DATA_W-1:0] wdata;
    } unit_req_t;

    typedef struct packed {
        logic               wup;
        logic               slp;
        logic [TSKID_W-1:0] tskid;
    } task_cmd_t;

    typedef struct packed {
        logic               sig;
        logic               pol;
        logic [SEMID_W-1:0] semid;
    } sem_cmd_t;

    typedef struct packed {
        logic             set;
        logic             clr;
        logic             ena_wr;
        logic [FLG_W-1:0] data;
    } flg_cmd_t;

endpackage
